/* rtl/csr_pkg.sv */
package csr_pkg;

	// privilege modes
	localparam logic [1:0] MODE_U = 2'd0;
	localparam logic [1:0] MODE_S = 2'd1;
	localparam logic [1:0] MODE_M = 2'd3;

	// csr ops, low bits of funct3
	localparam logic [1:0] OP_RW = 2'd1;
	localparam logic [1:0] OP_RS = 2'd2;
	localparam logic [1:0] OP_RC = 2'd3;

	// user level
	localparam logic [11:0] CSR_USTATUS  = 12'h000;
	localparam logic [11:0] CSR_UIE      = 12'h004;
	localparam logic [11:0] CSR_UTVEC    = 12'h005;
	localparam logic [11:0] CSR_USCRATCH = 12'h040;
	localparam logic [11:0] CSR_UEPC     = 12'h041;
	localparam logic [11:0] CSR_UCAUSE   = 12'h042;
	localparam logic [11:0] CSR_UTVAL    = 12'h043;
	localparam logic [11:0] CSR_UIP      = 12'h044;

	// supervisor level
	localparam logic [11:0] CSR_SSTATUS  = 12'h100;
	localparam logic [11:0] CSR_SEDELEG  = 12'h102;
	localparam logic [11:0] CSR_SIDELEG  = 12'h103;
	localparam logic [11:0] CSR_SIE      = 12'h104;
	localparam logic [11:0] CSR_STVEC    = 12'h105;
	localparam logic [11:0] CSR_SSCRATCH = 12'h140;
	localparam logic [11:0] CSR_SEPC     = 12'h141;
	localparam logic [11:0] CSR_SCAUSE   = 12'h142;
	localparam logic [11:0] CSR_STVAL    = 12'h143;
	localparam logic [11:0] CSR_SIP      = 12'h144;
	localparam logic [11:0] CSR_STIMECMP = 12'h5c0;	// custom

	// machine level
	localparam logic [11:0] CSR_MSTATUS  = 12'h300;
	localparam logic [11:0] CSR_MISA     = 12'h301;
	localparam logic [11:0] CSR_MEDELEG  = 12'h302;
	localparam logic [11:0] CSR_MIDELEG  = 12'h303;
	localparam logic [11:0] CSR_MIE      = 12'h304;
	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;
	localparam logic [11:0] CSR_MTVAL    = 12'h343;
	localparam logic [11:0] CSR_MIP      = 12'h344;
	localparam logic [11:0] CSR_MTIMECMP = 12'h7c0;	// custom

	// exception and interrupt codes
	localparam logic [30:0] EXC_I_MISALIGNED = 31'd0;
	localparam logic [30:0] EXC_ILLEGAL      = 31'd2;
	localparam logic [30:0] EXC_ECALL_U      = 31'd8;
	localparam logic [30:0] EXC_ECALL_S      = 31'd9;
	localparam logic [30:0] EXC_ECALL_M      = 31'd11;
	localparam logic [30:0] IRQ_S_TIMER      = 31'd5;
	localparam logic [30:0] IRQ_M_TIMER      = 31'd7;
	localparam logic [30:0] IRQ_S_EXT        = 31'd9;
	localparam logic [30:0] IRQ_M_EXT        = 31'd11;

	// uie sie mie upie spie mpie spp mpp
	localparam logic [31:0] MSTATUS_WMASK = 32'h0000_19bb;
	localparam logic [31:0] SSTATUS_MASK  = 32'h0000_0133;
	localparam logic [31:0] USTATUS_MASK  = 32'h0000_0011;
	// u, s and m timer/external enables
	localparam logic [31:0] MIE_WMASK     = 32'h0000_0bb1;
	localparam logic [31:0] SIE_MASK      = 32'h0000_0331;
	localparam logic [31:0] UIE_MASK      = 32'h0000_0111;
	localparam logic [31:0] EDELEG_MASK   = 32'h0000_ffff;
	localparam logic [31:0] IDELEG_MASK   = 32'h0000_0fff;

endpackage

/* rtl/csr_op_stage.sv */
`timescale 1ns/1ps

module csr_op_stage
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        csr_valid,
	input  logic [1:0]  csr_op,
	input  logic [11:0] csr_addr,
	input  logic [31:0] csr_src,
	input  logic        stall,
	input  logic [1:0]  current_mode,
	output logic [11:0] rd_addr,
	input  logic [31:0] rd_value,
	output logic [31:0] csr_rdata,
	output logic        csr_rvalid,
	output logic        csr_illegal,
	output logic        wb_en,
	output logic [11:0] wb_addr,
	output logic [31:0] wb_data
);
	import csr_pkg::*;

	logic        accept;
	logic        writes;
	logic        illegal;
	logic [31:0] keep;
	logic [31:0] old_value;
	logic [31:0] new_value;

	// bits of a written word that the register file stores
	function automatic logic [31:0] kept_bits(input logic [11:0] addr);
		logic [31:0] k;
		case (addr)
			CSR_MSTATUS: k = MSTATUS_WMASK;
			CSR_SSTATUS: k = SSTATUS_MASK;
			CSR_USTATUS: k = USTATUS_MASK;
			CSR_MIE:     k = MIE_WMASK;
			CSR_SIE:     k = SIE_MASK;
			CSR_UIE:     k = UIE_MASK;
			CSR_MEDELEG,
			CSR_SEDELEG: k = EDELEG_MASK;
			CSR_MIDELEG,
			CSR_SIDELEG: k = IDELEG_MASK;
			CSR_MTVEC, CSR_STVEC, CSR_UTVEC,
			CSR_MEPC, CSR_SEPC, CSR_UEPC:
				k = 32'hffff_fffc;	// low two bits fixed at zero
			CSR_MCAUSE, CSR_SCAUSE, CSR_UCAUSE,
			CSR_MTVAL, CSR_STVAL, CSR_UTVAL,
			CSR_MSCRATCH, CSR_SSCRATCH, CSR_USCRATCH:
				k = 32'hffff_ffff;
			default:     k = 32'b0;	// read-only or driven by hardware
		endcase
		return k;
	endfunction

	assign accept  = csr_valid && !stall;
	assign rd_addr = csr_addr;
	assign keep    = kept_bits(csr_addr);

	// value still in stage 2 wins over the register file
	assign old_value = (wb_en && (wb_addr == csr_addr)) ?
		((wb_data & keep) | (rd_value & ~keep)) : rd_value;

	// privilege in addr[9:8], read-only when addr[11:10] == 2'b11
	assign illegal = (csr_addr[9:8] > current_mode) || (writes && (&csr_addr[11:10]));

	always_comb
	begin
		case (csr_op)
			OP_RW:
			begin
				new_value = csr_src;
				writes    = 1'b1;
			end
			OP_RS:
			begin
				new_value = old_value | csr_src;
				writes    = |csr_src;	// zero source is a pure read
			end
			OP_RC:
			begin
				new_value = old_value & ~csr_src;
				writes    = |csr_src;
			end
			default:
			begin
				new_value = old_value;
				writes    = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			csr_rvalid  <= 1'b0;
			csr_illegal <= 1'b0;
			wb_en       <= 1'b0;
		end
		else
		begin
			csr_rvalid  <= accept;
			csr_illegal <= accept && illegal;
			wb_en       <= accept && !illegal && writes;	// single cycle per write
		end
	end

	// payload holds while stalled
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			csr_rdata <= old_value;
			wb_addr   <= csr_addr;
			wb_data   <= new_value;
		end
	end

endmodule

/* rtl/trap_unit.sv */
`timescale 1ns/1ps

module trap_unit
(
	input  logic        exception_pending,
	input  logic [30:0] exc_cause,
	input  logic        csr_illegal,
	input  logic        m_ret,
	input  logic        s_ret,
	input  logic        u_ret,
	input  logic [1:0]  current_mode,
	input  logic [31:0] mip,
	input  logic [31:0] mie,
	input  logic        m_gie,
	input  logic        s_gie,
	input  logic [31:0] medeleg,
	input  logic [31:0] mideleg,
	input  logic [31:0] sedeleg,
	input  logic [31:0] sideleg,
	output logic        trap_take,
	output logic [31:0] trap_cause,
	output logic [1:0]  trap_mode,
	output logic        ret_take,
	output logic [1:0]  ret_from
);
	import csr_pkg::*;

	logic [31:0] pending;
	logic        m_irq_ok;
	logic        s_irq_ok;
	logic [4:0]  code;
	logic        deleg_m;
	logic        deleg_s;

	assign pending  = mip & mie;
	assign m_irq_ok = (current_mode != MODE_M) || m_gie;
	assign s_irq_ok = (current_mode == MODE_U) || ((current_mode == MODE_S) && s_gie);

	// cause priority
	always_comb
	begin
		trap_take  = 1'b1;
		trap_cause = 32'b0;
		if (exception_pending)
			trap_cause = {1'b0, exc_cause};
		else if (csr_illegal)
			trap_cause = {1'b0, EXC_ILLEGAL};
		else if (pending[IRQ_M_EXT[4:0]] && m_irq_ok)
			trap_cause = {1'b1, IRQ_M_EXT};
		else if (pending[IRQ_M_TIMER[4:0]] && m_irq_ok)
			trap_cause = {1'b1, IRQ_M_TIMER};
		else if (pending[IRQ_S_EXT[4:0]] && s_irq_ok)
			trap_cause = {1'b1, IRQ_S_EXT};
		else if (pending[IRQ_S_TIMER[4:0]] && s_irq_ok)
			trap_cause = {1'b1, IRQ_S_TIMER};
		else
			trap_take = 1'b0;
	end

	assign code    = trap_cause[4:0];
	assign deleg_m = trap_cause[31] ? mideleg[code] : medeleg[code];
	assign deleg_s = trap_cause[31] ? sideleg[code] : sedeleg[code];

	// m delegates to s, s may pass it on to u
	always_comb
	begin
		trap_mode = MODE_M;
		if ((current_mode != MODE_M) && deleg_m)
			trap_mode = ((current_mode == MODE_U) && deleg_s) ? MODE_U : MODE_S;
	end

	assign ret_take = !trap_take && (m_ret || s_ret || u_ret);
	assign ret_from = m_ret ? MODE_M : (s_ret ? MODE_S : MODE_U);

endmodule

/* rtl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer
#(
	parameter int TIMER_W = 64
)
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        wb_en,
	input  logic [11:0] wb_addr,
	input  logic [31:0] wb_data,
	output logic        m_timer,
	output logic        s_timer
);
	import csr_pkg::*;

	logic [TIMER_W-1:0] cycle_cnt;
	logic [TIMER_W-1:0] mtimecmp;
	logic [TIMER_W-1:0] stimecmp;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cycle_cnt <= '0;
			mtimecmp  <= '1;	// far future
			stimecmp  <= '1;
			m_timer   <= 1'b0;
			s_timer   <= 1'b0;
		end
		else
		begin
			cycle_cnt <= cycle_cnt + 1'b1;
			if (wb_en && (wb_addr == CSR_MTIMECMP))
				mtimecmp <= TIMER_W'(wb_data);	// upper bits cleared
			if (wb_en && (wb_addr == CSR_STIMECMP))
				stimecmp <= TIMER_W'(wb_data);
			m_timer <= (cycle_cnt >= mtimecmp);
			s_timer <= (cycle_cnt >= stimecmp);
		end
	end

endmodule

/* rtl/csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile
(
	input  logic        clk,
	input  logic        nrst,
	input  logic [11:0] rd_addr,
	input  logic        wb_en,
	input  logic [11:0] wb_addr,
	input  logic [31:0] wb_data,
	input  logic        trap_take,
	input  logic [31:0] trap_cause,
	input  logic [1:0]  trap_mode,
	input  logic        ret_take,
	input  logic [1:0]  ret_from,
	input  logic [31:0] pc_exc,
	input  logic        m_timer,
	input  logic        s_timer,
	input  logic        m_ext_irq,
	input  logic        s_ext_irq,
	output logic [31:0] rd_value,
	output logic [1:0]  current_mode,
	output logic [31:0] mip,
	output logic [31:0] mie,
	output logic        m_gie,
	output logic        s_gie,
	output logic [31:0] medeleg,
	output logic [31:0] mideleg,
	output logic [31:0] sedeleg,
	output logic [31:0] sideleg,
	output logic        redirect_valid,
	output logic [31:0] redirect_pc
);
	import csr_pkg::*;

	// sstatus and ustatus are views of mstatus, same for the enables
	logic [31:0] mstatus;
	logic [31:2] mtvec;
	logic [31:2] stvec;
	logic [31:2] utvec;
	logic [31:2] mepc;
	logic [31:2] sepc;
	logic [31:2] uepc;
	logic [31:0] mcause;
	logic [31:0] scause;
	logic [31:0] ucause;
	logic [31:0] mtval;
	logic [31:0] stval;
	logic [31:0] utval;
	logic [31:0] mscratch;
	logic [31:0] sscratch;
	logic [31:0] uscratch;
	logic [31:0] tval_next;

	assign mip   = {20'b0, m_ext_irq, 1'b0, s_ext_irq, 1'b0, m_timer, 1'b0, s_timer, 5'b0};
	assign m_gie = mstatus[3];
	assign s_gie = mstatus[1];

	// only a misaligned fetch reports an address
	assign tval_next = (trap_cause == {1'b0, EXC_I_MISALIGNED}) ? pc_exc : 32'b0;

	always_comb
	begin
		case (rd_addr)
			CSR_MISA:     rd_value = 32'h4014_0100;	// rv32 with i, s, u
			CSR_MSTATUS:  rd_value = mstatus;
			CSR_MIE:      rd_value = mie;
			CSR_MIP:      rd_value = mip;
			CSR_MTVEC:    rd_value = {mtvec, 2'b00};
			CSR_MEPC:     rd_value = {mepc, 2'b00};
			CSR_MCAUSE:   rd_value = mcause;
			CSR_MTVAL:    rd_value = mtval;
			CSR_MSCRATCH: rd_value = mscratch;
			CSR_MEDELEG:  rd_value = medeleg;
			CSR_MIDELEG:  rd_value = mideleg;
			CSR_SSTATUS:  rd_value = mstatus & SSTATUS_MASK;
			CSR_SIE:      rd_value = mie & SIE_MASK;
			CSR_SIP:      rd_value = mip & SIE_MASK;
			CSR_STVEC:    rd_value = {stvec, 2'b00};
			CSR_SEPC:     rd_value = {sepc, 2'b00};
			CSR_SCAUSE:   rd_value = scause;
			CSR_STVAL:    rd_value = stval;
			CSR_SSCRATCH: rd_value = sscratch;
			CSR_SEDELEG:  rd_value = sedeleg;
			CSR_SIDELEG:  rd_value = sideleg;
			CSR_USTATUS:  rd_value = mstatus & USTATUS_MASK;
			CSR_UIE:      rd_value = mie & UIE_MASK;
			CSR_UIP:      rd_value = mip & UIE_MASK;
			CSR_UTVEC:    rd_value = {utvec, 2'b00};
			CSR_UEPC:     rd_value = {uepc, 2'b00};
			CSR_UCAUSE:   rd_value = ucause;
			CSR_UTVAL:    rd_value = utval;
			CSR_USCRATCH: rd_value = uscratch;
			default:      rd_value = 32'b0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= MODE_M;
			mstatus      <= 32'b0;
			mie          <= 32'b0;
			medeleg      <= 32'b0;
			mideleg      <= 32'b0;
			sedeleg      <= 32'b0;
			sideleg      <= 32'b0;
			mtvec        <= '0;
			stvec        <= '0;
			utvec        <= '0;
			mepc         <= '0;
			sepc         <= '0;
			uepc         <= '0;
			mcause       <= 32'b0;
			scause       <= 32'b0;
			ucause       <= 32'b0;
			mtval        <= 32'b0;
			stval        <= 32'b0;
			utval        <= 32'b0;
			mscratch     <= 32'b0;
			sscratch     <= 32'b0;
			uscratch     <= 32'b0;
		end
		else if (trap_take)
		begin
			current_mode <= trap_mode;
			case (trap_mode)
				MODE_M:
				begin
					mepc             <= pc_exc[31:2];
					mcause           <= trap_cause;
					mtval            <= tval_next;
					mstatus[7]       <= mstatus[3];	// mpie <= mie
					mstatus[3]       <= 1'b0;
					mstatus[12:11]   <= current_mode;
				end
				MODE_S:
				begin
					sepc       <= pc_exc[31:2];
					scause     <= trap_cause;
					stval      <= tval_next;
					mstatus[5] <= mstatus[1];	// spie <= sie
					mstatus[1] <= 1'b0;
					mstatus[8] <= current_mode[0];
				end
				default:
				begin
					uepc       <= pc_exc[31:2];
					ucause     <= trap_cause;
					utval      <= tval_next;
					mstatus[4] <= mstatus[0];
					mstatus[0] <= 1'b0;
				end
			endcase
		end
		else if (ret_take)
		begin
			case (ret_from)
				MODE_M:
				begin
					current_mode   <= mstatus[12:11];
					mstatus[3]     <= mstatus[7];
					mstatus[7]     <= 1'b1;
					mstatus[12:11] <= MODE_U;
				end
				MODE_S:
				begin
					current_mode <= mstatus[8] ? MODE_S : MODE_U;
					mstatus[1]   <= mstatus[5];
					mstatus[5]   <= 1'b1;
					mstatus[8]   <= 1'b0;
				end
				default:
				begin
					current_mode <= MODE_U;
					mstatus[0]   <= mstatus[4];
					mstatus[4]   <= 1'b1;
				end
			endcase
		end
		else if (wb_en)
		begin
			case (wb_addr)
				CSR_MSTATUS:  mstatus  <= wb_data & MSTATUS_WMASK;
				CSR_SSTATUS:  mstatus  <= (mstatus & ~SSTATUS_MASK) | (wb_data & SSTATUS_MASK);
				CSR_USTATUS:  mstatus  <= (mstatus & ~USTATUS_MASK) | (wb_data & USTATUS_MASK);
				CSR_MIE:      mie      <= wb_data & MIE_WMASK;
				CSR_SIE:      mie      <= (mie & ~SIE_MASK) | (wb_data & SIE_MASK);
				CSR_UIE:      mie      <= (mie & ~UIE_MASK) | (wb_data & UIE_MASK);
				CSR_MTVEC:    mtvec    <= wb_data[31:2];
				CSR_STVEC:    stvec    <= wb_data[31:2];
				CSR_UTVEC:    utvec    <= wb_data[31:2];
				CSR_MEPC:     mepc     <= wb_data[31:2];
				CSR_SEPC:     sepc     <= wb_data[31:2];
				CSR_UEPC:     uepc     <= wb_data[31:2];
				CSR_MCAUSE:   mcause   <= wb_data;
				CSR_SCAUSE:   scause   <= wb_data;
				CSR_UCAUSE:   ucause   <= wb_data;
				CSR_MTVAL:    mtval    <= wb_data;
				CSR_STVAL:    stval    <= wb_data;
				CSR_UTVAL:    utval    <= wb_data;
				CSR_MSCRATCH: mscratch <= wb_data;
				CSR_SSCRATCH: sscratch <= wb_data;
				CSR_USCRATCH: uscratch <= wb_data;
				CSR_MEDELEG:  medeleg  <= wb_data & EDELEG_MASK;
				CSR_MIDELEG:  mideleg  <= wb_data & IDELEG_MASK;
				CSR_SEDELEG:  sedeleg  <= wb_data & EDELEG_MASK;
				CSR_SIDELEG:  sideleg  <= wb_data & IDELEG_MASK;
				default: ;	// pending bits come from hardware
			endcase
		end
	end

	assign redirect_valid = trap_take || ret_take;

	// handler entry on a trap, saved epc on a return
	always_comb
	begin
		if (trap_take)
		begin
			case (trap_mode)
				MODE_S:  redirect_pc = {stvec, 2'b00};
				MODE_U:  redirect_pc = {utvec, 2'b00};
				default: redirect_pc = {mtvec, 2'b00};
			endcase
		end
		else
		begin
			case (ret_from)
				MODE_M:  redirect_pc = {mepc, 2'b00};
				MODE_S:  redirect_pc = {sepc, 2'b00};
				default: redirect_pc = {uepc, 2'b00};
			endcase
		end
	end

endmodule

/* rtl/csr_top.sv */
`timescale 1ns/1ps

module csr_top
#(
	parameter int TIMER_W = 64
)
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        csr_valid,
	input  logic [1:0]  csr_op,
	input  logic [11:0] csr_addr,
	input  logic [31:0] csr_src,
	input  logic        stall,
	input  logic        exception_pending,
	input  logic [30:0] exc_cause,
	input  logic [31:0] pc_exc,
	input  logic        m_ret,
	input  logic        s_ret,
	input  logic        u_ret,
	input  logic        m_ext_irq,
	input  logic        s_ext_irq,
	output logic [31:0] csr_rdata,
	output logic        csr_rvalid,
	output logic        csr_illegal,
	output logic [1:0]  current_mode,
	output logic        redirect_valid,
	output logic [31:0] redirect_pc
);

	// stage 1 to stage 2
	logic [11:0] rd_addr;
	logic [31:0] rd_value;
	logic        wb_en;
	logic [11:0] wb_addr;
	logic [31:0] wb_data;

	// trap decision
	logic        trap_take;
	logic [31:0] trap_cause;
	logic [1:0]  trap_mode;
	logic        ret_take;
	logic [1:0]  ret_from;

	// state seen by the trap unit
	logic [31:0] mip;
	logic [31:0] mie;
	logic        m_gie;
	logic        s_gie;
	logic [31:0] medeleg;
	logic [31:0] mideleg;
	logic [31:0] sedeleg;
	logic [31:0] sideleg;
	logic        m_timer;
	logic        s_timer;

	csr_op_stage i_op_stage
	(
		.clk          (clk),
		.nrst         (nrst),
		.csr_valid    (csr_valid),
		.csr_op       (csr_op),
		.csr_addr     (csr_addr),
		.csr_src      (csr_src),
		.stall        (stall),
		.current_mode (current_mode),
		.rd_addr      (rd_addr),
		.rd_value     (rd_value),
		.csr_rdata    (csr_rdata),
		.csr_rvalid   (csr_rvalid),
		.csr_illegal  (csr_illegal),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data)
	);

	trap_unit i_trap_unit
	(
		.exception_pending (exception_pending),
		.exc_cause         (exc_cause),
		.csr_illegal       (csr_illegal),
		.m_ret             (m_ret),
		.s_ret             (s_ret),
		.u_ret             (u_ret),
		.current_mode      (current_mode),
		.mip               (mip),
		.mie               (mie),
		.m_gie             (m_gie),
		.s_gie             (s_gie),
		.medeleg           (medeleg),
		.mideleg           (mideleg),
		.sedeleg           (sedeleg),
		.sideleg           (sideleg),
		.trap_take         (trap_take),
		.trap_cause        (trap_cause),
		.trap_mode         (trap_mode),
		.ret_take          (ret_take),
		.ret_from          (ret_from)
	);

	csr_timer
	#(
		.TIMER_W (TIMER_W)
	)
	i_timer
	(
		.clk     (clk),
		.nrst    (nrst),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.m_timer (m_timer),
		.s_timer (s_timer)
	);

	csr_regfile i_regfile
	(
		.clk            (clk),
		.nrst           (nrst),
		.rd_addr        (rd_addr),
		.wb_en          (wb_en),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.trap_take      (trap_take),
		.trap_cause     (trap_cause),
		.trap_mode      (trap_mode),
		.ret_take       (ret_take),
		.ret_from       (ret_from),
		.pc_exc         (pc_exc),
		.m_timer        (m_timer),
		.s_timer        (s_timer),
		.m_ext_irq      (m_ext_irq),
		.s_ext_irq      (s_ext_irq),
		.rd_value       (rd_value),
		.current_mode   (current_mode),
		.mip            (mip),
		.mie            (mie),
		.m_gie          (m_gie),
		.s_gie          (s_gie),
		.medeleg        (medeleg),
		.mideleg        (mideleg),
		.sedeleg        (sedeleg),
		.sideleg        (sideleg),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

/* dv/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// expected privileged state, tvec/epc/cause/tval/scratch indexed by mode code
logic [31:0] exp_status;
logic [31:0] exp_ie;
logic [31:0] exp_medeleg;
logic [31:0] exp_mideleg;
logic [31:0] exp_sedeleg;
logic [31:0] exp_sideleg;
logic [31:0] exp_tvec [4];
logic [31:0] exp_epc [4];
logic [31:0] exp_cause [4];
logic [31:0] exp_tval [4];
logic [31:0] exp_scratch [4];
logic [1:0]  exp_mode;

function automatic void clear_state();
	exp_status  = 32'b0;
	exp_ie      = 32'b0;
	exp_medeleg = 32'b0;
	exp_mideleg = 32'b0;
	exp_sedeleg = 32'b0;
	exp_sideleg = 32'b0;
	exp_mode    = MODE_M;
	for (int i = 0; i < 4; i++)
	begin
		exp_tvec[i]    = 32'b0;
		exp_epc[i]     = 32'b0;
		exp_cause[i]   = 32'b0;
		exp_tval[i]    = 32'b0;
		exp_scratch[i] = 32'b0;
	end
endfunction

function automatic logic [31:0] expected_read(input logic [11:0] addr);
	logic [31:0] r;
	case (addr)
		CSR_MSTATUS: r = exp_status;
		CSR_MIE:     r = exp_ie;
		CSR_MEDELEG: r = exp_medeleg;
		CSR_MIDELEG: r = exp_mideleg;
		CSR_SEDELEG: r = exp_sedeleg;
		CSR_SIDELEG: r = exp_sideleg;
		default:
		begin
			case (addr[7:0])	// per-mode registers, mode in addr[9:8]
				8'h05:   r = exp_tvec[addr[9:8]];
				8'h40:   r = exp_scratch[addr[9:8]];
				8'h41:   r = exp_epc[addr[9:8]];
				8'h42:   r = exp_cause[addr[9:8]];
				8'h43:   r = exp_tval[addr[9:8]];
				default: r = 32'b0;
			endcase
		end
	endcase
	return r;
endfunction

function automatic void apply_write(input logic [11:0] addr, input logic [31:0] d);
	case (addr)
		CSR_MSTATUS: exp_status = d & MSTATUS_WMASK;
		CSR_MIE:     exp_ie = d & MIE_WMASK;
		CSR_MEDELEG: exp_medeleg = d & EDELEG_MASK;
		CSR_MIDELEG: exp_mideleg = d & IDELEG_MASK;
		CSR_SEDELEG: exp_sedeleg = d & EDELEG_MASK;
		CSR_SIDELEG: exp_sideleg = d & IDELEG_MASK;
		default:
		begin
			case (addr[7:0])
				8'h05:   exp_tvec[addr[9:8]] = d & ~32'h3;	// low bits fixed at zero
				8'h40:   exp_scratch[addr[9:8]] = d;
				8'h41:   exp_epc[addr[9:8]] = d & ~32'h3;
				8'h42:   exp_cause[addr[9:8]] = d;
				8'h43:   exp_tval[addr[9:8]] = d;
				default: ;	// timer compares live outside the model
			endcase
		end
	endcase
endfunction

// delegation: M hands to S, S may hand on to U, never below current mode
function automatic logic [1:0] trap_target(input logic [31:0] cause);
	logic dm;
	logic ds;
	dm = cause[31] ? exp_mideleg[cause[4:0]] : exp_medeleg[cause[4:0]];
	ds = cause[31] ? exp_sideleg[cause[4:0]] : exp_sedeleg[cause[4:0]];
	if ((exp_mode == MODE_M) || !dm)
		return MODE_M;
	if ((exp_mode == MODE_U) && ds)
		return MODE_U;
	return MODE_S;
endfunction

function automatic void enter_trap(input logic [31:0] cause, input logic [31:0] pc);
	logic [1:0] tgt;
	tgt = trap_target(cause);
	exp_epc[tgt]   = pc & ~32'h3;
	exp_cause[tgt] = cause;
	exp_tval[tgt]  = (cause == 32'b0) ? pc : 32'b0;	// misaligned fetch only
	case (tgt)
		MODE_M:
		begin
			exp_status[7]     = exp_status[3];
			exp_status[3]     = 1'b0;
			exp_status[12:11] = exp_mode;
		end
		MODE_S:
		begin
			exp_status[5] = exp_status[1];
			exp_status[1] = 1'b0;
			exp_status[8] = exp_mode[0];
		end
		default:
		begin
			exp_status[4] = exp_status[0];
			exp_status[0] = 1'b0;
		end
	endcase
	exp_mode = tgt;
endfunction

function automatic void leave_trap(input logic [1:0] from);
	case (from)
		MODE_M:
		begin
			exp_mode          = exp_status[12:11];
			exp_status[3]     = exp_status[7];
			exp_status[7]     = 1'b1;
			exp_status[12:11] = MODE_U;
		end
		MODE_S:
		begin
			exp_mode      = exp_status[8] ? MODE_S : MODE_U;
			exp_status[1] = exp_status[5];
			exp_status[5] = 1'b1;
			exp_status[8] = 1'b0;
		end
		default:
		begin
			exp_mode      = MODE_U;
			exp_status[0] = exp_status[4];
			exp_status[4] = 1'b1;
		end
	endcase
endfunction

`endif

/* dv/tb_csr_top.sv */
`timescale 1ns/1ps

module tb_csr_top;
	import csr_pkg::*;

	`include "csr_model.svh"

	localparam int N_RANDOM = 400;	// random accesses
	localparam int N_EXC    = 40;	// delegation rounds, about 16 operations each
	localparam int N_RET    = 30;	// return rounds, about 12 operations each
	localparam int N_OPS    = N_RANDOM + 16 * N_EXC + 12 * N_RET + 32;
	localparam logic [11:0] ADDR_TAB [18] = '{
		CSR_MSCRATCH, CSR_MEPC, CSR_MTVEC, CSR_MCAUSE, CSR_MTVAL, CSR_MEDELEG,
		CSR_MIDELEG, CSR_MIE, CSR_MSTATUS, CSR_SSCRATCH, CSR_SEPC, CSR_STVEC,
		CSR_SCAUSE, CSR_STVAL, CSR_SEDELEG, CSR_SIDELEG, CSR_USCRATCH, CSR_UEPC};

	logic        clk;
	logic        nrst;
	logic        csr_valid;
	logic [1:0]  csr_op;
	logic [11:0] csr_addr;
	logic [31:0] csr_src;
	logic        stall;
	logic        exception_pending;
	logic [30:0] exc_cause;
	logic [31:0] pc_exc;
	logic        m_ret;
	logic        s_ret;
	logic        u_ret;
	logic        m_ext_irq;
	logic        s_ext_irq;
	logic [31:0] csr_rdata;
	logic        csr_rvalid;
	logic        csr_illegal;
	logic [1:0]  current_mode;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic [31:0] rng;
	logic [31:0] cycles;

	csr_top #(.TIMER_W(64)) i_dut
	(
		.clk (clk), .nrst (nrst), .csr_valid (csr_valid), .csr_op (csr_op),
		.csr_addr (csr_addr), .csr_src (csr_src), .stall (stall),
		.exception_pending (exception_pending), .exc_cause (exc_cause), .pc_exc (pc_exc),
		.m_ret (m_ret), .s_ret (s_ret), .u_ret (u_ret), .m_ext_irq (m_ext_irq),
		.s_ext_irq (s_ext_irq), .csr_rdata (csr_rdata), .csr_rvalid (csr_rvalid),
		.csr_illegal (csr_illegal), .current_mode (current_mode),
		.redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		cycles <= nrst ? cycles + 1 : 32'b0;	// mirrors the dut cycle counter roughly

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	// one csr instruction, result checked a cycle later
	task automatic run_op(input logic [1:0] op, input logic [11:0] addr, input logic [31:0] src);
		logic [31:0] old;
		logic [31:0] merged;
		logic        wr;
		old = expected_read(addr);
		wr  = (op == OP_RW) || (src != 32'b0);
		case (op)
			OP_RW:   merged = src;
			OP_RS:   merged = old | src;
			default: merged = old & ~src;
		endcase
		csr_valid = 1'b1;
		csr_op    = op;
		csr_addr  = addr;
		csr_src   = src;
		@(posedge clk);
		#1;
		csr_valid = 1'b0;
		if (wr)
			apply_write(addr, merged);
		check_val("csr_rvalid", csr_rvalid, 1);
		check_val("csr_illegal", csr_illegal, 0);
		check_val("csr_rdata", csr_rdata, old);
	endtask

	task automatic illegal_access(input logic [11:0] addr, input logic [31:0] pc);
		csr_valid = 1'b1;
		csr_op    = OP_RW;
		csr_addr  = addr;
		csr_src   = next_random();
		pc_exc    = pc;
		@(posedge clk);
		#1;
		csr_valid = 1'b0;
		check_val("csr_illegal", csr_illegal, 1);
		check_val("redirect_valid", redirect_valid, 1);
		check_val("redirect_pc", redirect_pc, exp_tvec[trap_target({1'b0, EXC_ILLEGAL})]);
		enter_trap({1'b0, EXC_ILLEGAL}, pc);
		@(posedge clk);
		#1;
		check_val("current_mode", current_mode, exp_mode);
		check_val("redirect_valid", redirect_valid, 0);
		run_op(OP_RS, {2'b00, exp_mode, 8'h42}, 32'b0);	// cause of the handler mode
	endtask

	task automatic raise_exc(input logic [30:0] cause, input logic [31:0] pc);
		@(posedge clk);	// let a pending write-back land first
		#1;
		exception_pending = 1'b1;
		exc_cause         = cause;
		pc_exc            = pc;
		#2;
		check_val("redirect_valid", redirect_valid, 1);
		check_val("redirect_pc", redirect_pc, exp_tvec[trap_target({1'b0, cause})]);
		@(posedge clk);
		#1;
		exception_pending = 1'b0;
		enter_trap({1'b0, cause}, pc);
		check_val("current_mode", current_mode, exp_mode);
	endtask

	task automatic do_return(input logic [1:0] from);
		@(posedge clk);
		#1;
		m_ret = (from == MODE_M);
		s_ret = (from == MODE_S);
		#2;
		check_val("redirect_valid", redirect_valid, 1);
		check_val("redirect_pc", redirect_pc, exp_epc[from]);
		@(posedge clk);
		#1;
		m_ret = 1'b0;
		s_ret = 1'b0;
		leave_trap(from);
		check_val("current_mode", current_mode, exp_mode);
	endtask

	// from M, drop to the given mode through mret
	task automatic enter_mode(input logic [1:0] mode);
		run_op(OP_RW, CSR_MSTATUS, (exp_status & ~32'h1800) | {19'b0, mode, 11'b0});
		run_op(OP_RW, CSR_MEPC, next_random());
		do_return(MODE_M);
	endtask

	initial
	begin
		#(N_OPS * 20 * 8);
		$display("watchdog expired before the tests completed");
		$display("*** FAILED ***");
		$fatal(1);
	end

	initial
	begin
		logic [11:0] addr;
		logic [11:0] last_addr;
		logic [1:0]  op;
		logic [1:0]  tgt;
		logic [31:0] src;
		logic [30:0] cause;
		rng = 32'h027eb686;
		clk = 1'b0;
		nrst = 1'b0;
		csr_valid = 1'b0;
		csr_op = OP_RW;
		csr_addr = 12'b0;
		csr_src = 32'b0;
		stall = 1'b0;
		exception_pending = 1'b0;
		exc_cause = 31'b0;
		pc_exc = 32'b0;
		m_ret = 1'b0;
		s_ret = 1'b0;
		u_ret = 1'b0;
		m_ext_irq = 1'b0;
		s_ext_irq = 1'b0;
		clear_state();
		repeat (10) @(posedge clk);
		#1;
		nrst = 1'b1;
		check_val("current_mode", current_mode, MODE_M);

		// random read/write/set/clear, often back to back on one address
		last_addr = CSR_MSCRATCH;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			addr = (next_random() % 4 == 0) ? last_addr : ADDR_TAB[next_random() % 18];
			op   = 2'(next_random() % 3) + 2'd1;
			src  = (next_random() % 5 == 0) ? 32'b0 : next_random();
			run_op(op, addr, src);
			last_addr = addr;
		end

		// illegal accesses, no delegation
		run_op(OP_RW, CSR_MEDELEG, 32'b0);
		run_op(OP_RW, CSR_MIDELEG, 32'b0);
		run_op(OP_RW, CSR_MTVEC, next_random());
		enter_mode(MODE_U);
		illegal_access(CSR_MSCRATCH, next_random());
		enter_mode(MODE_U);
		illegal_access(CSR_SSCRATCH, next_random());
		enter_mode(MODE_S);
		illegal_access(CSR_MSTATUS, next_random());
		illegal_access(12'hc00, next_random());	// read-only space
		enter_mode(MODE_U);
		illegal_access(12'hc01, next_random());

		// exceptions under random delegation, code 3 is never delegated
		for (int i = 0; i < N_EXC; i++)
		begin
			run_op(OP_RW, CSR_MEDELEG, next_random() & ~32'h8);
			run_op(OP_RW, CSR_SEDELEG, next_random());
			run_op(OP_RW, CSR_MIDELEG, next_random());
			run_op(OP_RW, CSR_SIDELEG, next_random());
			run_op(OP_RW, CSR_MTVEC, next_random());
			run_op(OP_RW, CSR_STVEC, next_random());
			run_op(OP_RW, CSR_UTVEC, next_random());
			case (next_random() % 3)
				0:       enter_mode(MODE_U);
				1:       enter_mode(MODE_S);
				default: enter_mode(MODE_M);
			endcase
			case (next_random() % 5)
				0:       cause = EXC_I_MISALIGNED;
				1:       cause = EXC_ILLEGAL;
				2:       cause = EXC_ECALL_U;
				3:       cause = EXC_ECALL_S;
				default: cause = EXC_ECALL_M;
			endcase
			raise_exc(cause, next_random());
			tgt = exp_mode;
			run_op(OP_RS, {2'b00, tgt, 8'h41}, 32'b0);	// epc
			run_op(OP_RS, {2'b00, tgt, 8'h42}, 32'b0);	// cause
			run_op(OP_RS, {2'b00, tgt, 8'h43}, 32'b0);	// tval
			raise_exc(31'd3, next_random());	// breakpoint back to M
		end

		// mret and sret from random saved state
		for (int i = 0; i < N_RET; i++)
		begin
			src = next_random() & ~32'h1800;
			case (next_random() % 3)
				0:       src[12:11] = MODE_M;
				1:       src[12:11] = MODE_S;
				default: src[12:11] = MODE_U;
			endcase
			run_op(OP_RW, CSR_MSTATUS, src);
			run_op(OP_RW, CSR_MEPC, next_random());
			do_return(MODE_M);
			if (exp_mode == MODE_M)
				run_op(OP_RS, CSR_MSTATUS, 32'b0);	// mpie set, mpp back to u
			raise_exc(31'd3, next_random());
			run_op(OP_RS, CSR_MSTATUS, 32'b0);
			run_op(OP_RW, CSR_MSTATUS, next_random());
			run_op(OP_RW, CSR_SEPC, next_random());
			do_return(MODE_S);
			raise_exc(31'd3, next_random());
			run_op(OP_RS, CSR_MSTATUS, 32'b0);
		end

		// machine timer interrupt
		run_op(OP_RW, CSR_MSTATUS, 32'b0);
		run_op(OP_RW, CSR_MTIMECMP, cycles + 32'd20);
		run_op(OP_RS, CSR_MIE, 32'h80);
		run_op(OP_RS, CSR_MSTATUS, 32'h8);
		while (!redirect_valid)
		begin
			@(posedge clk);
			#1;
		end
		check_val("redirect_pc", redirect_pc, exp_tvec[MODE_M]);
		enter_trap({1'b1, IRQ_M_TIMER}, pc_exc);
		@(posedge clk);
		#1;
		check_val("current_mode", current_mode, exp_mode);
		run_op(OP_RS, CSR_MCAUSE, 32'b0);
		run_op(OP_RS, CSR_MSTATUS, 32'b0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* sources.f */
+incdir+dv
rtl/csr_pkg.sv
rtl/csr_op_stage.sv
rtl/trap_unit.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
dv/tb_csr_top.sv

/* run.sh */
#!/bin/sh
# build and run the csr testbench with verilator
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_csr_top \
	-o sim_csr > build.log 2>&1 &&
./obj_dir/sim_csr > sim.log 2>&1
grep -q "\*\*\* PASSED \*\*\*" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log and build.log"; exit 1; }
